// File: logic/mmio_pkg.sv
package mmio_pkg;

    ////////////////////////////////////////
    // Bus and board types
    ////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [31:0] mmio_addr_t;
    typedef logic [3:0]  byte_mask_t;

    typedef logic [63:0] sw_bus_t;
    typedef logic [7:0]  key_bus_t;

    // Four groups of 10 bits: a..g, dot, two digit enables
    typedef logic [39:0] seg_bus_t;

    // Active high, bit 0 drives segment a
    typedef logic [6:0]  seg_pattern_t;

    typedef enum logic {
        CNT_STOPPED,
        CNT_RUNNING
    } cnt_state_t;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////

    localparam mmio_addr_t DTCM_BASE = 32'h8010_0000;
    localparam mmio_addr_t SW0_ADDR  = 32'h8020_0000;
    localparam mmio_addr_t SW1_ADDR  = 32'h8020_0004;
    localparam mmio_addr_t KEY_ADDR  = 32'h8020_0010;
    localparam mmio_addr_t SEG_ADDR  = 32'h8020_0020;
    localparam mmio_addr_t LED_ADDR  = 32'h8020_0040;
    localparam mmio_addr_t CNT_ADDR  = 32'h8020_0050;

    // Counter command words
    localparam word_t CNT_CMD_START = 32'h8000_0000;
    localparam word_t CNT_CMD_STOP  = 32'hffff_ffff;

    // Returned for unmapped and write-only addresses
    localparam word_t BAD_READ = 32'hdead_beef;

endpackage

// File: logic/perip_bridge.sv
module perip_bridge #(
    parameter int DTCM_AW = 10
) (
    input  logic                     clk,
    input  logic                     rst,

    // Write port
    input  mmio_pkg::mmio_addr_t     perip_waddr,
    input  mmio_pkg::word_t          perip_wdata,
    input  logic                     perip_wen,
    input  mmio_pkg::byte_mask_t     perip_mask,

    // Read port
    input  mmio_pkg::mmio_addr_t     perip_raddr,
    output mmio_pkg::word_t          perip_rdata,

    // Board inputs and outputs
    input  mmio_pkg::sw_bus_t        sw_in,
    input  mmio_pkg::key_bus_t       key_in,
    output mmio_pkg::word_t          led_out,
    output mmio_pkg::word_t          seg_value,

    // DTCM side
    output logic                     dtcm_we,
    output mmio_pkg::byte_mask_t     dtcm_mask,
    output logic [DTCM_AW-1:0]       dtcm_waddr,
    output logic [DTCM_AW-1:0]       dtcm_raddr,
    input  mmio_pkg::word_t          dtcm_rdata,

    // Counter side
    output logic                     cnt_we,
    input  mmio_pkg::word_t          cnt_value,

    // Write data shared by the peers
    output mmio_pkg::word_t          wdata
);
    import mmio_pkg::*;

    // First byte address past the DTCM window
    localparam mmio_addr_t DTCM_LIMIT = DTCM_BASE + mmio_addr_t'(4 << DTCM_AW);

    logic  wr_in_dtcm;
    logic  rd_in_dtcm;
    word_t rd_next;

    ////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////

    assign wr_in_dtcm = (perip_waddr >= DTCM_BASE) && (perip_waddr < DTCM_LIMIT);

    assign dtcm_we    = perip_wen && wr_in_dtcm;
    assign dtcm_mask  = perip_mask;
    assign dtcm_waddr = perip_waddr[DTCM_AW+1:2];
    assign cnt_we     = perip_wen && (perip_waddr == CNT_ADDR);
    assign wdata      = perip_wdata;

    // Board registers take the whole word, the mask is for DTCM only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led_out   <= '0;
            seg_value <= '0;
        end else if (perip_wen) begin
            if (perip_waddr == LED_ADDR) begin
                led_out <= perip_wdata;
            end
            if (perip_waddr == SEG_ADDR) begin
                seg_value <= perip_wdata;
            end
        end
    end

    ////////////////////////////////////////
    // Read select
    ////////////////////////////////////////

    assign rd_in_dtcm = (perip_raddr >= DTCM_BASE) && (perip_raddr < DTCM_LIMIT);
    assign dtcm_raddr = perip_raddr[DTCM_AW+1:2];

    always_comb begin
        if (rd_in_dtcm) begin
            rd_next = dtcm_rdata;
        end else begin
            case (perip_raddr)
                SW0_ADDR: rd_next = sw_in[31:0];
                SW1_ADDR: rd_next = sw_in[63:32];
                KEY_ADDR: rd_next = {24'd0, key_in};
                SEG_ADDR: rd_next = seg_value;
                CNT_ADDR: rd_next = cnt_value;
                // LED is write-only and falls through here
                default:  rd_next = BAD_READ;
            endcase
        end
    end

    // Sampled before this edge's write lands, so same-address reads see old data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            perip_rdata <= '0;
        end else begin
            perip_rdata <= rd_next;
        end
    end

endmodule

// File: logic/dtcm_ram.sv
module dtcm_ram #(
    parameter int DTCM_AW = 10
) (
    input  logic                 clk,

    // Write side
    input  logic                 we,
    input  mmio_pkg::byte_mask_t mask,
    input  logic [DTCM_AW-1:0]   waddr,
    input  mmio_pkg::word_t      wdata,

    // Read side
    input  logic [DTCM_AW-1:0]   raddr,
    output mmio_pkg::word_t      rdata
);
    import mmio_pkg::*;

    localparam int DEPTH = 1 << DTCM_AW;

    word_t mem [DEPTH];

    ////////////////////////////////////////
    // Byte-masked write
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Asynchronous read
    ////////////////////////////////////////

    // The bridge registers this, so read latency stays one cycle
    assign rdata = mem[raddr];

endmodule

// File: logic/cycle_counter.sv
module cycle_counter #(
    parameter int CNT_DIV = 50000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            we,
    input  mmio_pkg::word_t wdata,
    output mmio_pkg::word_t value
);
    import mmio_pkg::*;

    // Keep at least one prescaler bit when CNT_DIV is 1
    localparam int PW = (CNT_DIV > 1) ? $clog2(CNT_DIV) : 1;
    localparam logic [PW-1:0] PRESC_LAST = PW'(CNT_DIV - 1);

    cnt_state_t    state;
    logic [PW-1:0] presc;
    word_t         count;

    logic          cmd_start;
    logic          cmd_stop;

    assign cmd_start = we && (wdata == CNT_CMD_START);
    assign cmd_stop  = we && (wdata == CNT_CMD_STOP);

    ////////////////////////////////////////
    // Command FSM and prescaled count
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= CNT_STOPPED;
            presc <= '0;
            count <= '0;
        end else if (cmd_start) begin
            // Restart clears everything, even while running
            state <= CNT_RUNNING;
            presc <= '0;
            count <= '0;
        end else if (cmd_stop) begin
            // Stop wins over a pending increment at this edge
            state <= CNT_STOPPED;
        end else if (state == CNT_RUNNING) begin
            if (presc == PRESC_LAST) begin
                presc <= '0;
                count <= count + 32'd1;
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

    assign value = count;

endmodule

// File: logic/seg_scanner.sv
module seg_scanner #(
    parameter int SCAN_DIV = 100000
) (
    input  logic               clk,
    input  logic               rst,
    input  mmio_pkg::word_t    seg_value,
    output mmio_pkg::seg_bus_t seg_out
);
    import mmio_pkg::*;

    localparam int DW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [DW-1:0] DIV_LAST = DW'(SCAN_DIV - 1);

    // Digit 0 on every group with the low enables, dots off
    localparam seg_bus_t SEG_RESET = {4{2'b01, 1'b0, 7'h3f}};

    logic [DW-1:0] div_cnt;
    logic          phase;
    logic          phase_nxt;
    seg_bus_t      seg_nxt;

    ////////////////////////////////////////
    // Hex to segment decode
    ////////////////////////////////////////

    function automatic seg_pattern_t hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0:    hex_to_seg = 7'h3f;
            4'h1:    hex_to_seg = 7'h06;
            4'h2:    hex_to_seg = 7'h5b;
            4'h3:    hex_to_seg = 7'h4f;
            4'h4:    hex_to_seg = 7'h66;
            4'h5:    hex_to_seg = 7'h6d;
            4'h6:    hex_to_seg = 7'h7d;
            4'h7:    hex_to_seg = 7'h07;
            4'h8:    hex_to_seg = 7'h7f;
            4'h9:    hex_to_seg = 7'h6f;
            4'ha:    hex_to_seg = 7'h77;
            4'hb:    hex_to_seg = 7'h7c;
            4'hc:    hex_to_seg = 7'h39;
            4'hd:    hex_to_seg = 7'h5e;
            4'he:    hex_to_seg = 7'h79;
            default: hex_to_seg = 7'h71;
        endcase
    endfunction

    ////////////////////////////////////////
    // Scan divider
    ////////////////////////////////////////

    assign phase_nxt = (div_cnt == DIV_LAST) ? ~phase : phase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            phase   <= 1'b0;
        end else begin
            div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            phase   <= phase_nxt;
        end
    end

    ////////////////////////////////////////
    // Group drive
    ////////////////////////////////////////

    // Built from the next phase so the enables flip together with it
    always_comb begin
        for (int g = 0; g < 4; g++) begin
            if (phase_nxt) begin
                seg_nxt[10*g +: 7] = hex_to_seg(seg_value[8*g+4 +: 4]);
                seg_nxt[10*g+8]    = 1'b0;
                seg_nxt[10*g+9]    = 1'b1;
            end else begin
                seg_nxt[10*g +: 7] = hex_to_seg(seg_value[8*g +: 4]);
                seg_nxt[10*g+8]    = 1'b1;
                seg_nxt[10*g+9]    = 1'b0;
            end
            seg_nxt[10*g+7] = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_out <= SEG_RESET;
        end else begin
            seg_out <= seg_nxt;
        end
    end

endmodule

// File: logic/mmio_top.sv
module mmio_top #(
    parameter int DTCM_AW  = 10,
    parameter int CNT_DIV  = 50000,
    parameter int SCAN_DIV = 100000
) (
    input  logic                 clk,
    input  logic                 rst,

    // Write port
    input  mmio_pkg::mmio_addr_t perip_waddr,
    input  mmio_pkg::word_t      perip_wdata,
    input  logic                 perip_wen,
    input  mmio_pkg::byte_mask_t perip_mask,

    // Read port
    input  mmio_pkg::mmio_addr_t perip_raddr,
    output mmio_pkg::word_t      perip_rdata,

    // Board
    input  mmio_pkg::sw_bus_t    sw_in,
    input  mmio_pkg::key_bus_t   key_in,
    output mmio_pkg::word_t      led_out,
    output mmio_pkg::seg_bus_t   seg_out
);
    import mmio_pkg::*;

    word_t              seg_value;
    word_t              wdata;
    word_t              dtcm_rdata;
    word_t              cnt_value;
    logic               dtcm_we;
    logic               cnt_we;
    byte_mask_t         dtcm_mask;
    logic [DTCM_AW-1:0] dtcm_waddr;
    logic [DTCM_AW-1:0] dtcm_raddr;

    ////////////////////////////////////////
    // Bridge and peers
    ////////////////////////////////////////

    perip_bridge #(
        .DTCM_AW (DTCM_AW)
    ) u_bridge (
        .clk         (clk),
        .rst         (rst),
        .perip_waddr (perip_waddr),
        .perip_wdata (perip_wdata),
        .perip_wen   (perip_wen),
        .perip_mask  (perip_mask),
        .perip_raddr (perip_raddr),
        .perip_rdata (perip_rdata),
        .sw_in       (sw_in),
        .key_in      (key_in),
        .led_out     (led_out),
        .seg_value   (seg_value),
        .dtcm_we     (dtcm_we),
        .dtcm_mask   (dtcm_mask),
        .dtcm_waddr  (dtcm_waddr),
        .dtcm_raddr  (dtcm_raddr),
        .dtcm_rdata  (dtcm_rdata),
        .cnt_we      (cnt_we),
        .cnt_value   (cnt_value),
        .wdata       (wdata)
    );

    dtcm_ram #(
        .DTCM_AW (DTCM_AW)
    ) u_dtcm (
        .clk   (clk),
        .we    (dtcm_we),
        .mask  (dtcm_mask),
        .waddr (dtcm_waddr),
        .wdata (wdata),
        .raddr (dtcm_raddr),
        .rdata (dtcm_rdata)
    );

    cycle_counter #(
        .CNT_DIV (CNT_DIV)
    ) u_counter (
        .clk   (clk),
        .rst   (rst),
        .we    (cnt_we),
        .wdata (wdata),
        .value (cnt_value)
    );

    seg_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) u_scanner (
        .clk       (clk),
        .rst       (rst),
        .seg_value (seg_value),
        .seg_out   (seg_out)
    );

endmodule

// File: verification/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the DUT sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: verification/tb_mmio.sv
module tb_mmio;
    timeunit 1ns;
    timeprecision 1ps;

    import mmio_pkg::*;

    localparam int DTCM_AW      = 6;
    localparam int CNT_DIV      = 4;
    localparam int SCAN_DIV     = 8;
    localparam int RESET_CYCLES = 8;

    localparam int DTCM_WORDS  = 1 << DTCM_AW;
    localparam int DTCM_OPS    = 200;
    localparam int REG_ROUNDS  = 4;
    localparam int DISP_CYCLES = 6 * SCAN_DIV;
    localparam int CNT_RUNS    = 6;
    localparam int CNT_MAX_GAP = 31;

    // Run limit is twice the summed test lengths
    localparam int TEST_CYCLES = RESET_CYCLES + 4
                               + DTCM_WORDS + 2 * DTCM_OPS
                               + 3 * REG_ROUNDS + 10
                               + DISP_CYCLES + 4
                               + CNT_RUNS * (CNT_MAX_GAP + 2 * CNT_DIV + 12);
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    // Hex digits 0 to f with segment a in bit 0
    localparam seg_pattern_t SEG_TABLE [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic       clk;
    logic       rst;
    mmio_addr_t perip_waddr;
    word_t      perip_wdata;
    logic       perip_wen;
    byte_mask_t perip_mask;
    mmio_addr_t perip_raddr;
    word_t      perip_rdata;
    sw_bus_t    sw_in;
    key_bus_t   key_in;
    word_t      led_out;
    seg_bus_t   seg_out;

    // Reference state and requests to the compare process
    word_t       shadow [DTCM_WORDS];
    word_t       seg_ref;
    logic [31:0] lfsr_state;
    int          edge_cnt;
    logic        rd_req;
    word_t       rd_exp;
    string       rd_name;
    logic        led_req;
    word_t       led_exp;
    logic        seg_watch;

    tb_clock #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    mmio_top #(
        .DTCM_AW  (DTCM_AW),
        .CNT_DIV  (CNT_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .perip_waddr (perip_waddr),
        .perip_wdata (perip_wdata),
        .perip_wen   (perip_wen),
        .perip_mask  (perip_mask),
        .perip_raddr (perip_raddr),
        .perip_rdata (perip_rdata),
        .sw_in       (sw_in),
        .key_in      (key_in),
        .led_out     (led_out),
        .seg_out     (seg_out)
    );

    ////////////////////////////////////////
    // Reference models
    ////////////////////////////////////////

    // Taps at bits 32 22 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input byte_mask_t mask);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t fill_word(input mmio_addr_t addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6b1d_02c5;
    endfunction

    // Phase after a number of edges since reset
    function automatic logic scan_phase(input int edges);
        return ((edges / SCAN_DIV) % 2) == 1;
    endfunction

    function automatic seg_bus_t display_pattern(input word_t value, input logic phase);
        seg_bus_t   res;
        logic [3:0] nib;
        for (int g = 0; g < 4; g++) begin
            nib = phase ? value[8*g+4 +: 4] : value[8*g +: 4];
            res[10*g +: 7] = SEG_TABLE[nib];
            res[10*g+7]    = 1'b0;
            res[10*g+8]    = ~phase;
            res[10*g+9]    = phase;
        end
        return res;
    endfunction

    // k edges strictly between start and stop
    function automatic word_t frozen_count(input int k);
        return word_t'(k / CNT_DIV);
    endfunction

    ////////////////////////////////////////
    // Checks and stimulus helpers
    ////////////////////////////////////////

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_seg(input string name, input seg_bus_t expected,
                             input seg_bus_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_write(input mmio_addr_t addr, input word_t data,
                               input byte_mask_t mask);
        perip_waddr = addr;
        perip_wdata = data;
        perip_mask  = mask;
        perip_wen   = 1'b1;
    endtask

    task automatic expect_read(input mmio_addr_t addr, input word_t expected,
                               input string name);
        perip_raddr = addr;
        rd_exp      = expected;
        rd_name     = name;
        rd_req      = 1'b1;
    endtask

    task automatic step();
        @(negedge clk);
        perip_wen = 1'b0;
        rd_req    = 1'b0;
        led_req   = 1'b0;
    endtask

    ////////////////////////////////////////
    // Edge count, run limit and compare
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            edge_cnt = 0;
        end else begin
            edge_cnt = edge_cnt + 1;
        end
        if (edge_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", edge_cnt);
            $display("=== FAIL ===");
            $fatal(1, "simulation timeout");
        end
    end

    // Requests are taken at the rising edge and checked at the next falling edge
    initial begin : compare
        logic  take_rd;
        word_t take_rd_exp;
        string take_rd_name;
        logic  take_led;
        word_t take_led_exp;
        logic  take_seg;
        word_t take_seg_val;
        forever begin
            @(posedge clk);
            take_rd      = rd_req;
            take_rd_exp  = rd_exp;
            take_rd_name = rd_name;
            take_led     = led_req;
            take_led_exp = led_exp;
            take_seg     = seg_watch;
            take_seg_val = seg_ref;
            @(negedge clk);
            if (take_rd) begin
                check_word(take_rd_name, take_rd_exp, perip_rdata);
            end
            if (take_led) begin
                check_word("led_out", take_led_exp, led_out);
            end
            if (take_seg) begin
                check_seg("display scan",
                          display_pattern(take_seg_val, scan_phase(edge_cnt)),
                          seg_out);
            end
        end
    end

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic reset_values();
        check_word("reset rdata", 32'd0, perip_rdata);
        check_word("reset led_out", 32'd0, led_out);
        check_seg("reset display", display_pattern(32'd0, 1'b0), seg_out);
        expect_read(CNT_ADDR, 32'd0, "reset count");
        step();
    endtask

    task automatic dtcm_traffic();
        logic [63:0] r;
        int          idx;
        mmio_addr_t  addr;
        word_t       data;
        byte_mask_t  mask;
        // DTCM contents are undefined after reset so every word gets a value first
        for (int i = 0; i < DTCM_WORDS; i++) begin
            addr = DTCM_BASE + mmio_addr_t'(4 * i);
            shadow[i] = fill_word(addr);
            drive_write(addr, shadow[i], 4'hf);
            step();
        end
        for (int n = 0; n < DTCM_OPS; n++) begin
            rand_bits(DTCM_AW, r);
            idx = int'(r[DTCM_AW-1:0]);
            rand_bits(4, r);
            mask = r[3:0];
            rand_bits(32, r);
            data = r[31:0];
            addr = DTCM_BASE + mmio_addr_t'(4 * idx);
            drive_write(addr, data, mask);
            expect_read(addr, shadow[idx], "dtcm same-cycle read");
            step();
            shadow[idx] = merge_bytes(shadow[idx], data, mask);
            expect_read(addr, shadow[idx], "dtcm readback");
            step();
        end
    endtask

    task automatic board_registers();
        logic [63:0] r;
        for (int n = 0; n < REG_ROUNDS; n++) begin
            rand_bits(64, r);
            sw_in = r;
            rand_bits(8, r);
            key_in = r[7:0];
            expect_read(SW0_ADDR, sw_in[31:0], "switch word 0");
            step();
            expect_read(SW1_ADDR, sw_in[63:32], "switch word 1");
            step();
            expect_read(KEY_ADDR, {24'd0, key_in}, "keys");
            step();
        end
        // Mask of zero still writes the whole LED word
        rand_bits(32, r);
        drive_write(LED_ADDR, r[31:0], 4'h0);
        led_req = 1'b1;
        led_exp = r[31:0];
        expect_read(LED_ADDR, BAD_READ, "led read");
        step();
        rand_bits(32, r);
        drive_write(SEG_ADDR, r[31:0], 4'h1);
        seg_ref = r[31:0];
        step();
        expect_read(SEG_ADDR, seg_ref, "segment readback");
        step();
        expect_read(32'h8020_0008, BAD_READ, "unmapped register gap");
        step();
        expect_read(DTCM_BASE + mmio_addr_t'(4 << DTCM_AW), BAD_READ, "past dtcm end");
        step();
        expect_read(32'h0000_0000, BAD_READ, "address zero");
        step();
    endtask

    task automatic display_scan();
        logic [63:0] r;
        rand_bits(32, r);
        drive_write(SEG_ADDR, r[31:0], 4'hf);
        seg_ref = r[31:0];
        step();
        seg_watch = 1'b1;
        repeat (DISP_CYCLES) step();
        seg_watch = 1'b0;
    endtask

    task automatic counter_start_stop();
        logic [63:0] r;
        int          k;
        word_t       frozen;
        for (int run = 0; run < CNT_RUNS; run++) begin
            rand_bits(5, r);
            k = int'(r[4:0]);
            drive_write(CNT_ADDR, CNT_CMD_START, 4'hf);
            step();
            repeat (k) step();
            drive_write(CNT_ADDR, CNT_CMD_STOP, 4'hf);
            step();
            frozen = frozen_count(k);
            expect_read(CNT_ADDR, frozen, "count after stop");
            step();
            // Neither command word and therefore ignored
            rand_bits(32, r);
            drive_write(CNT_ADDR, r[31:0] & 32'h7fff_fff0, 4'hf);
            step();
            repeat (2 * CNT_DIV + 3) step();
            expect_read(CNT_ADDR, frozen, "count while stopped");
            step();
            drive_write(CNT_ADDR, CNT_CMD_START, 4'hf);
            step();
            expect_read(CNT_ADDR, 32'd0, "count after restart");
            step();
            drive_write(CNT_ADDR, CNT_CMD_STOP, 4'hf);
            step();
        end
    endtask

    initial begin : stimulus
        perip_waddr = '0;
        perip_wdata = '0;
        perip_wen   = 1'b0;
        perip_mask  = '0;
        perip_raddr = '0;
        sw_in       = '0;
        key_in      = '0;
        lfsr_state  = 32'h39e;
        seg_ref     = '0;
        rd_req      = 1'b0;
        rd_exp      = '0;
        rd_name     = "";
        led_req     = 1'b0;
        led_exp     = '0;
        seg_watch   = 1'b0;

        @(negedge rst);
        reset_values();
        dtcm_traffic();
        board_registers();
        display_scan();
        counter_start_stop();

        // Let the last compare finish
        step();
        step();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tb.f
logic/mmio_pkg.sv
logic/perip_bridge.sv
logic/dtcm_ram.sv
logic/cycle_counter.sv
logic/seg_scanner.sv
logic/mmio_top.sv
verification/tb_clock.sv
verification/tb_mmio.sv

// File: Makefile
TOOL       := verilator
FLAGS      := --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
TOP        := tb_mmio
FILELIST   := tb.f

OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "=== PASS ===" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
